/* src/com_rx_pkg.sv */
package com_rx_pkg;

    // ********************
    // basic types
    // ********************

    typedef logic [7:0] byte_t;      // one received byte
    typedef logic [2:0] phase_t;     // bit position within a byte

    // ********************
    // protocol constants
    // ********************

    localparam byte_t PREAMBLE_BYTE = 8'h5A;   // repeated ahead of sync
    localparam byte_t SYNC_BYTE     = 8'h01;   // start of payload

    // frame state machine
    typedef enum logic [2:0] {
        IDLE,
        WAIT,
        HUNT,
        SEEK_SYNC,
        READ,
        DONE
    } rx_state_t;

    // hunter status toward the frame FSM
    typedef struct packed {
        logic locked;      // preamble confirmed
        logic boundary;    // aligned byte in window, only while locked
    } lock_s;

    // output byte strobe
    typedef struct packed {
        logic  valid;      // high for one cycle per byte
        byte_t data;
    } rx_byte_s;

endpackage

/* src/bit_window.sv */
module bit_window (
    input  logic               clk,
    input  logic               rst,
    input  logic               arm,
    input  logic               din,
    output com_rx_pkg::byte_t  window,
    output com_rx_pkg::phase_t bit_phase
);

    // ********************
    // serial shift window
    // ********************

    // the newest bit enters at the lsb, so after eight shifts the
    // first bit of a byte sits at the msb
    com_rx_pkg::byte_t  shift_q;
    com_rx_pkg::phase_t phase_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shift_q <= '0;
        end else if (arm) begin
            shift_q <= {shift_q[6:0], din};   // msb first on the wire
        end else begin
            shift_q <= '0;                    // clean start for each hunt
        end
    end

    // ********************
    // bit phase counter
    // ********************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase_q <= '0;
        end else if (arm) begin
            phase_q <= phase_q + 3'd1;        // wraps modulo 8
        end else begin
            phase_q <= '0;
        end
    end

    assign window    = shift_q;
    assign bit_phase = phase_q;

endmodule

/* src/preamble_hunter.sv */
module preamble_hunter #(
    parameter int unsigned preamble_count = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               arm,
    input  com_rx_pkg::byte_t  window,
    input  com_rx_pkg::phase_t bit_phase,
    output com_rx_pkg::lock_s  lock
);

    localparam int unsigned    cnt_w    = $clog2(preamble_count + 1);
    localparam logic [cnt_w-1:0] cnt_full = cnt_w'(preamble_count);

    logic               locked_q;
    com_rx_pkg::phase_t match_phase;     // phase that carried the first preamble
    logic [cnt_w-1:0]   match_cnt;       // preambles seen back to back
    logic               hit;
    logic               at_phase;

    assign hit      = (window == com_rx_pkg::PREAMBLE_BYTE);
    assign at_phase = (bit_phase == match_phase);

    // ********************
    // search and confirm
    // ********************

    // any phase may start a candidate; after that only the recorded
    // phase is checked, once per byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            locked_q    <= 1'b0;
            match_phase <= '0;
            match_cnt   <= '0;
        end else if (!arm) begin
            locked_q    <= 1'b0;
            match_phase <= '0;
            match_cnt   <= '0;
        end else if (!locked_q) begin
            if (match_cnt == cnt_full) begin
                locked_q <= 1'b1;                   // enough preambles
            end else if (match_cnt == '0) begin
                if (hit) begin
                    match_phase <= bit_phase;
                    match_cnt   <= cnt_w'(1);
                end
            end else if (at_phase) begin
                if (hit) begin
                    match_cnt <= match_cnt + cnt_w'(1);
                end else begin
                    match_cnt <= '0;                // broken run, search again
                end
            end
        end
    end

    // ********************
    // lock status
    // ********************

    always_comb begin
        lock.locked   = locked_q;
        lock.boundary = locked_q & at_phase;   // every eighth cycle once locked
    end

endmodule

/* src/frame_ctrl.sv */
module frame_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fire,
    input  com_rx_pkg::byte_t    window,
    input  com_rx_pkg::lock_s    lock,
    output logic                 arm,
    output com_rx_pkg::rx_byte_s rx_byte
);

    com_rx_pkg::rx_state_t state;
    com_rx_pkg::rx_state_t next_state;

    logic              sync_seen;
    logic              emit;
    logic              valid_q;
    com_rx_pkg::byte_t data_q;

    assign sync_seen = lock.boundary && (window == com_rx_pkg::SYNC_BYTE);
    assign emit      = (state == com_rx_pkg::READ) && lock.boundary && fire;

    // ********************
    // state register
    // ********************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= com_rx_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ********************
    // next state
    // ********************

    always_comb begin
        next_state = state;
        case (state)
            com_rx_pkg::IDLE: begin
                next_state = com_rx_pkg::WAIT;
            end
            com_rx_pkg::WAIT: begin
                if (fire) begin
                    next_state = com_rx_pkg::HUNT;
                end
            end
            com_rx_pkg::HUNT: begin
                if (lock.locked) begin
                    next_state = com_rx_pkg::SEEK_SYNC;
                end
            end
            com_rx_pkg::SEEK_SYNC: begin
                if (sync_seen) begin
                    next_state = com_rx_pkg::READ;   // payload follows
                end
            end
            com_rx_pkg::READ: begin
                if (lock.boundary && !fire) begin
                    next_state = com_rx_pkg::DONE;   // end of transfer
                end
            end
            com_rx_pkg::DONE: begin
                next_state = com_rx_pkg::WAIT;
            end
            default: begin
                next_state = com_rx_pkg::IDLE;
            end
        endcase
    end

    // front end runs only while a frame is in progress
    assign arm = (state == com_rx_pkg::HUNT) ||
                 (state == com_rx_pkg::SEEK_SYNC) ||
                 (state == com_rx_pkg::READ);

    // ********************
    // output strobe
    // ********************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= emit;       // one cycle per byte
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            data_q <= window;
        end
    end

    always_comb begin
        rx_byte.valid = valid_q;
        rx_byte.data  = data_q;
    end

endmodule

/* src/com_rx_top.sv */
module com_rx_top #(
    parameter int unsigned preamble_count = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fire,
    input  logic                 din,
    output com_rx_pkg::rx_byte_s rx_byte
);

    logic               arm;
    com_rx_pkg::byte_t  window;
    com_rx_pkg::phase_t bit_phase;
    com_rx_pkg::lock_s  lock;

    // ********************
    // serial front end
    // ********************

    bit_window u_bit_window (
        .clk       (clk),
        .rst       (rst),
        .arm       (arm),
        .din       (din),
        .window    (window),
        .bit_phase (bit_phase)
    );

    preamble_hunter #(
        .preamble_count (preamble_count)
    ) u_preamble_hunter (
        .clk       (clk),
        .rst       (rst),
        .arm       (arm),
        .window    (window),
        .bit_phase (bit_phase),
        .lock      (lock)
    );

    // ********************
    // frame control
    // ********************

    frame_ctrl u_frame_ctrl (
        .clk     (clk),
        .rst     (rst),
        .fire    (fire),
        .window  (window),
        .lock    (lock),
        .arm     (arm),
        .rx_byte (rx_byte)
    );

endmodule

/* test/com_rx_assertions.sv */
module com_rx_assertions (
    input logic                  clk,
    input logic                  rst,
    input logic                  arm,
    input com_rx_pkg::rx_state_t state,
    input com_rx_pkg::rx_byte_s  rx_byte
);

    logic valid;
    int   width_fails = 0;
    int   arm_fails   = 0;
    int   state_fails = 0;
    int   fail_count;

    assign valid      = rx_byte.valid;
    assign fail_count = width_fails + arm_fails + state_fails;   // read by the testbench

    strobe_width: assert property (@(posedge clk) disable iff (rst) valid |=> !valid)
        else begin
            $error("rx_byte.valid stayed high for two cycles");
            width_fails++;
        end

    strobe_armed: assert property (@(posedge clk) disable iff (rst) valid |-> arm)
        else begin
            $error("rx_byte.valid high while the front end is disarmed");
            arm_fails++;
        end

    // bytes only come out of the read phase
    strobe_state: assert property (@(posedge clk) disable iff (rst)
                                   $rose(valid) |-> state == com_rx_pkg::READ)
        else begin
            $error("rx_byte.valid rose outside READ");
            state_fails++;
        end

endmodule

/* test/com_rx_tb.sv */
module com_rx_tb;

    localparam int         PERIOD       = 20;
    localparam int         GAP_CYCLES   = 16;
    localparam int         IDLE_CYCLES  = 24;
    localparam logic [3:0] RANDOM_NOISE = 4'hF;
    localparam logic [7:0] PREAMBLE     = 8'h5A;
    localparam logic [7:0] SYNC         = 8'h01;

    // payload[0] goes out first
    typedef struct packed {
        logic [3:0]      noise;      // zero bits ahead of the preamble
        logic [2:0]      n_pre;
        logic            decoy_en;   // lone preamble plus decoy ahead of the run
        logic [7:0]      decoy;
        logic [2:0]      n_pay;
        logic [0:3][7:0] payload;
    } frame_s;

    logic                 clk;
    logic                 rst;
    logic                 fire;
    logic                 din;
    com_rx_pkg::rx_byte_s rx_byte;

    integer            seed;
    frame_s            frames[$];
    com_rx_pkg::byte_t got_q[$];
    time               got_time[$];
    int                value_errors;
    int                missing_errors;
    int                extra_errors;
    int                first;

    com_rx_top #(
        .preamble_count (2)
    ) dut (
        .clk     (clk),
        .rst     (rst),
        .fire    (fire),
        .din     (din),
        .rx_byte (rx_byte)
    );

    bind frame_ctrl com_rx_assertions u_assertions (
        .clk     (clk),
        .rst     (rst),
        .arm     (arm),
        .state   (state),
        .rx_byte (rx_byte)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

    // collect every strobed byte, sampled away from the rising edge
    always @(negedge clk) begin
        if (!rst && rx_byte.valid) begin
            got_q.push_back(rx_byte.data);
            got_time.push_back($time);
        end
    end

    // ********************
    // frame table
    // ********************

    task automatic add_frame(input logic [3:0] noise, input logic [2:0] n_pre,
                             input logic decoy_en, input logic [7:0] decoy,
                             input logic [2:0] n_pay, input logic [0:3][7:0] payload);
        frame_s f;
        f = '{noise: noise, n_pre: n_pre, decoy_en: decoy_en, decoy: decoy,
              n_pay: n_pay, payload: payload};
        if (noise == RANDOM_NOISE) begin
            f.noise = 4'($unsigned($random(seed)) % 8);
        end
        frames.push_back(f);
    endtask

    // a sync byte right after a lone preamble only frames data if one preamble locks
    task automatic load_table();
        add_frame(4'd0, 3'd2, 1'b0, 8'h00, 3'd4, {8'hA5, 8'h3C, 8'h0F, 8'hE1});
        add_frame(4'd1, 3'd2, 1'b0, 8'h00, 3'd4, {8'h12, 8'h34, 8'h56, 8'h78});
        add_frame(4'd2, 3'd2, 1'b0, 8'h00, 3'd4, {8'h9A, 8'hBC, 8'hDE, 8'hF0});
        add_frame(4'd3, 3'd2, 1'b0, 8'h00, 3'd4, {8'h5A, 8'h01, 8'h5A, 8'h01});
        add_frame(4'd4, 3'd2, 1'b0, 8'h00, 3'd4, {8'hFF, 8'h00, 8'h80, 8'h7F});
        add_frame(4'd5, 3'd2, 1'b0, 8'h00, 3'd4, {8'hC3, 8'h81, 8'h18, 8'h66});
        add_frame(4'd6, 3'd2, 1'b0, 8'h00, 3'd4, {8'h01, 8'h02, 8'h04, 8'h08});
        add_frame(4'd7, 3'd2, 1'b0, 8'h00, 3'd4, {8'hAA, 8'h55, 8'hCC, 8'h33});
        add_frame(4'd0, 3'd2, 1'b1, SYNC, 3'd4, {8'h11, 8'h22, 8'h33, 8'h44});
        add_frame(4'd3, 3'd5, 1'b0, 8'h00, 3'd3, {8'h6B, 8'h5A, 8'h90, 8'h00});
        add_frame(RANDOM_NOISE, 3'd2, 1'b0, 8'h00, 3'd2, {8'hDE, 8'hAD, 8'h00, 8'h00});
        add_frame(RANDOM_NOISE, 3'd2, 1'b1, SYNC, 3'd1, {8'hBE, 8'h00, 8'h00, 8'h00});
        add_frame(RANDOM_NOISE, 3'd3, 1'b0, 8'h00, 3'd4, {8'h0F, 8'hF0, 8'h3C, 8'hC3});
    endtask

    function automatic int frame_cycles(input frame_s f);
        int n_bytes;
        n_bytes = int'(f.n_pre) + 1 + int'(f.n_pay);
        if (f.decoy_en) begin
            n_bytes += 2;
        end
        return 3 + int'(f.noise) + 8 * n_bytes + GAP_CYCLES;
    endfunction

    // ********************
    // serializer
    // ********************

    task automatic send_bit(input logic b);
        din = b;
        @(posedge clk);
        #2;
    endtask

    task automatic send_byte(input logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            send_bit(b[7]);       // msb first
            b = b << 1;
        end
    endtask

    task automatic send_frame(input frame_s f);
        logic [0:3][7:0] pay;
        pay  = f.payload;
        fire = 1'b1;              // one cycle ahead of the first bit
        @(posedge clk);
        #2;
        repeat (int'(f.noise)) send_bit(1'b0);
        if (f.decoy_en) begin
            send_byte(PREAMBLE);
            send_byte(f.decoy);
        end
        repeat (int'(f.n_pre)) send_byte(PREAMBLE);
        send_byte(SYNC);
        for (int k = 0; k < int'(f.n_pay); k++) begin
            send_byte(pay[0]);
            pay = pay << 8;
        end
        din = 1'b0;
        @(posedge clk);
        #2;
        fire = 1'b0;
        repeat (GAP_CYCLES) @(posedge clk);
        #2;
    endtask

    // ********************
    // scoreboard
    // ********************

    task automatic check_frame(input int idx, input int start, input frame_s f);
        logic [0:3][7:0] pay;
        int              n_got;
        int              n_exp;
        pay   = f.payload;
        n_got = got_q.size() - start;
        n_exp = int'(f.n_pay);
        for (int k = 0; k < n_exp && k < n_got; k++) begin
            assert (got_q[start + k] == pay[0]) else begin
                $display("FAIL %0t rx_byte.data got 0x%02h expected 0x%02h",
                         got_time[start + k], got_q[start + k], pay[0]);
                value_errors++;
            end
            pay = pay << 8;
        end
        assert (n_got >= n_exp) else begin
            $display("frame %0d: only %0d of %0d payload bytes arrived", idx, n_got, n_exp);
            missing_errors += n_exp - n_got;
        end
        assert (n_got <= n_exp) else begin
            $display("frame %0d: %0d bytes arrived beyond the payload", idx, n_got - n_exp);
            extra_errors += n_got - n_exp;
        end
    endtask

    task automatic final_report(input logic timed_out);
        int prop_errors;
        prop_errors = dut.u_frame_ctrl.u_assertions.fail_count;
        $display("bytes %0d, wrong %0d, missing %0d, extra %0d, assertion %0d, timeout %0d",
                 got_q.size(), value_errors, missing_errors, extra_errors, prop_errors,
                 int'(timed_out));
        if (!timed_out && value_errors + missing_errors + extra_errors + prop_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    initial begin
        seed           = 32'h3d52;
        value_errors   = 0;
        missing_errors = 0;
        extra_errors   = 0;
        rst            = 1'b1;
        fire           = 1'b0;
        din            = 1'b0;
        load_table();
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (IDLE_CYCLES) begin   // din toggles with fire low
            send_bit(~din);
        end
        din = 1'b0;
        assert (got_q.size() == 0) else begin
            $display("%0d bytes came out while fire was low", got_q.size());
            extra_errors += got_q.size();
        end
        foreach (frames[i]) begin
            first = got_q.size();
            send_frame(frames[i]);
            check_frame(i, first, frames[i]);
        end
        final_report(1'b0);
    end

    // watchdog
    initial begin
        longint cycles;
        #1;
        cycles = 3 + IDLE_CYCLES;
        foreach (frames[i]) begin
            cycles += frame_cycles(frames[i]);
        end
        #(cycles * PERIOD * 2);
        $display("timeout: the run did not finish after %0d cycles", cycles * 2);
        final_report(1'b1);
    end

endmodule

/* flist.f */
src/com_rx_pkg.sv
src/bit_window.sv
src/preamble_hunter.sv
src/frame_ctrl.sv
src/com_rx_top.sv
test/com_rx_assertions.sv
test/com_rx_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = com_rx_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SIM_ARGS  = +verilator+error+limit+100
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(SIM) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
